// ==== rtl/ttc_defs.svh ====
// Timer counter lite shared widths and APB register byte offsets
`ifndef TTC_DEFS_SVH
`define TTC_DEFS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define TTC_CNT_W        16        // Counter, interval and match width
`define TTC_ADDR_W       8         // APB address width

// ----------------------------------------
// Register map, byte offsets
// ----------------------------------------
`define TTC_OFF_CTRL     8'h00     // Control register
`define TTC_OFF_INTERVAL 8'h04     // Interval reload value
`define TTC_OFF_MATCH1   8'h08     // Match 1 value
`define TTC_OFF_MATCH2   8'h0C     // Match 2 value
`define TTC_OFF_MATCH3   8'h10     // Match 3 value
`define TTC_OFF_COUNT    8'h14     // Current count, read only
`define TTC_OFF_INTR     8'h18     // Interrupt status, clear on read
`define TTC_OFF_INTR_EN  8'h1C     // Interrupt enable

// Status and enable words are 6 bits wide
`define TTC_INTR_W       6

`endif

// ==== rtl/ttc_reg_pkg.sv ====
// Bus-side types of the timer counter lite: control fields and register index
package ttc_reg_pkg;

  // ----------------------------------------
  // Control register layout
  // ----------------------------------------
  // Bit 0 is count_en, bit 5 the restart strobe
  typedef struct packed {
    logic       count_restart;  // Self clearing, write pulse only
    logic [2:0] match_en;       // Match 3..1 compare enables
    logic       interval_mode;  // 1 = reload at interval, 0 = wrap
    logic       count_en;       // Counter runs while high
  } ctrl_t;

  // ----------------------------------------
  // Register index
  // ----------------------------------------
  // Order follows the offset map, one slot per word
  typedef enum logic [2:0] {
    idx_ctrl     = 3'd0,   // Control
    idx_interval = 3'd1,   // Interval value
    idx_match1   = 3'd2,   // Match 1
    idx_match2   = 3'd3,   // Match 2
    idx_match3   = 3'd4,   // Match 3
    idx_count    = 3'd5,   // Count, read only
    idx_intr     = 3'd6,   // Status, read clears
    idx_intr_en  = 3'd7    // Enable mask
  } reg_idx_e;

  // Reset value of the control word
  localparam ctrl_t CTRL_RESET = '0;

endpackage

// ==== rtl/ttc_intr_pkg.sv ====
// Interrupt-side types of the timer counter lite: event word in two views
package ttc_intr_pkg;

  // ----------------------------------------
  // Event word fields
  // ----------------------------------------
  // MSB to LSB, bit 0 is the interval event
  typedef struct packed {
    logic spare;      // Tied low, never sets
    logic overflow;   // Wrap at all ones
    logic match3;     // Count equals match 3
    logic match2;     // Count equals match 2
    logic match1;     // Count equals match 1
    logic interval;   // Reload at interval value
  } intr_fields_t;

  // Same 6 bits, either named or as a vector
  // Vector view used for masking, OR and the bus
  typedef union packed {
    logic [5:0]   vec;
    intr_fields_t fields;
  } intr_word_u;

  // Empty word, reset value of all event registers
  localparam intr_word_u INTR_NONE = '0;

endpackage

// ==== rtl/ttc_counter_lite.sv ====
// Timer counter lite event producer: 16-bit count with mode wrap and match compare
`timescale 1ns/1ns
`include "ttc_defs.svh"

module ttc_counter_lite (
  input  logic                  pclk22,
  input  logic                  n_p_reset22,
  input  logic                  count_en,       // Advance on each edge
  input  logic                  interval_mode,  // Reload at interval_val
  input  logic [3:1]            match_en,       // Per-comparator enable
  input  logic                  count_restart,  // One-cycle zero request
  input  logic [`TTC_CNT_W-1:0] interval_val,
  input  logic [`TTC_CNT_W-1:0] match1_val,
  input  logic [`TTC_CNT_W-1:0] match2_val,
  input  logic [`TTC_CNT_W-1:0] match3_val,
  output logic [`TTC_CNT_W-1:0] count_val,
  output logic                  interval_intr,  // Pulse on interval reload
  output logic                  overflow_intr,  // Pulse on wrap to zero
  output logic [3:1]            match_intr      // Level while count matches
);

  logic [`TTC_CNT_W-1:0] count_q;
  logic [`TTC_CNT_W-1:0] match_val [1:3];    // Indexed like match_intr
  logic                  at_interval;
  logic                  at_all_ones;
  logic                  wrap_interval;
  logic                  wrap_overflow;

  assign match_val[1] = match1_val;
  assign match_val[2] = match2_val;
  assign match_val[3] = match3_val;

  assign count_val = count_q;

  // ----------------------------------------
  // Wrap conditions
  // ----------------------------------------
  assign at_interval = (count_q == interval_val);
  assign at_all_ones = &count_q;

  // Restart overrides both wraps
  assign wrap_interval = count_en & ~count_restart & interval_mode & at_interval;
  assign wrap_overflow = count_en & ~count_restart & ~interval_mode & at_all_ones;

  // ----------------------------------------
  // Count register
  // ----------------------------------------
  always_ff @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      count_q <= '0;
    end
    else if (count_restart)
    begin
      count_q <= '0;                           // Restart wins
    end
    else if (wrap_interval)
    begin
      count_q <= '0;                           // Reload at interval
    end
    else if (count_en)
    begin
      count_q <= count_q + 1'b1;               // Overflow wraps naturally
    end
  end

  // ----------------------------------------
  // Registered events
  // ----------------------------------------
  always_ff @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      interval_intr <= 1'b0;
      overflow_intr <= 1'b0;
      match_intr    <= '0;
    end
    else
    begin
      interval_intr <= wrap_interval;          // High the cycle count is 0
      overflow_intr <= wrap_overflow;
      // Match levels follow the count one edge late
      for (int i = 1; i <= 3; i++)
      begin
        match_intr[i] <= match_en[i] & (count_q == match_val[i]);
      end
    end
  end

endmodule

// ==== rtl/ttc_interrupt_lite.sv ====
// Timer counter lite interrupt block: edge detect, enable mask and sticky status
`timescale 1ns/1ns

module ttc_interrupt_lite (
  input  logic       pclk22,
  input  logic       n_p_reset22,
  input  logic [5:0] pwdata,             // Enable write data
  input  logic       intr_en_reg_sel,    // Load enable register
  input  logic       clear_interrupt,    // Status read strobe
  input  logic       interval_intr,
  input  logic [3:1] match_intr,
  input  logic       overflow_intr,
  output logic       interrupt,          // OR of status bits
  output logic [5:0] interrupt_reg_out,
  output logic [5:0] interrupt_en_out
);

  ttc_intr_pkg::intr_word_u intr_detect;     // Raw event word
  ttc_intr_pkg::intr_word_u int_sync_reg;    // Events one cycle late
  ttc_intr_pkg::intr_word_u int_cycle_reg;   // Rising edges only
  logic [5:0]               interrupt_reg;   // Sticky status
  logic [5:0]               interrupt_en_reg;
  logic                     interrupt_set;   // Edge seen last cycle

  // ----------------------------------------
  // Event packing
  // ----------------------------------------
  always_comb
  begin
    intr_detect.fields.spare    = 1'b0;
    intr_detect.fields.overflow = overflow_intr;
    intr_detect.fields.match3   = match_intr[3];
    intr_detect.fields.match2   = match_intr[2];
    intr_detect.fields.match1   = match_intr[1];
    intr_detect.fields.interval = interval_intr;
  end

  assign interrupt         = |interrupt_reg;
  assign interrupt_reg_out = interrupt_reg;
  assign interrupt_en_out  = interrupt_en_reg;

  // ----------------------------------------
  // Edge detect and status
  // ----------------------------------------
  always_ff @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      int_sync_reg  <= ttc_intr_pkg::INTR_NONE;
      int_cycle_reg <= ttc_intr_pkg::INTR_NONE;
      interrupt_reg <= '0;
      interrupt_set <= 1'b0;
    end
    else
    begin
      int_sync_reg      <= intr_detect;
      // New events only, a held match level fires once
      int_cycle_reg.vec <= intr_detect.vec & ~int_sync_reg.vec;
      interrupt_set     <= |int_cycle_reg.vec;

      if (clear_interrupt && !interrupt_set)
      begin
        // Clear keeps only what lands this edge
        interrupt_reg <= int_cycle_reg.vec & interrupt_en_reg;
      end
      else
      begin
        interrupt_reg <= interrupt_reg | (int_cycle_reg.vec & interrupt_en_reg);
      end
    end
  end

  // ----------------------------------------
  // Enable register
  // ----------------------------------------
  always_ff @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      interrupt_en_reg <= '0;
    end
    else if (intr_en_reg_sel)
    begin
      interrupt_en_reg <= pwdata;              // Loads at the write edge
    end
  end

endmodule

// ==== rtl/ttc_regs_lite.sv ====
// Timer counter lite APB register slave: decode, config registers, read mux, strobes
`timescale 1ns/1ns
`include "ttc_defs.svh"

module ttc_regs_lite (
  input  logic                     pclk22,
  input  logic                     n_p_reset22,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`TTC_ADDR_W-1:0]   paddr,
  input  logic [31:0]              pwdata,
  input  logic [`TTC_CNT_W-1:0]    count_val,
  input  ttc_intr_pkg::intr_word_u interrupt_reg_out,
  input  ttc_intr_pkg::intr_word_u interrupt_en_out,
  output logic [31:0]              prdata,
  output logic                     count_en,
  output logic                     interval_mode,
  output logic [3:1]               match_en,
  output logic                     count_restart,    // One-cycle pulse
  output logic [`TTC_CNT_W-1:0]    interval_val,
  output logic [`TTC_CNT_W-1:0]    match1_val,
  output logic [`TTC_CNT_W-1:0]    match2_val,
  output logic [`TTC_CNT_W-1:0]    match3_val,
  output logic                     intr_en_reg_sel,  // Enable write strobe
  output logic                     clear_interrupt   // Status read strobe
);

  ttc_reg_pkg::reg_idx_e reg_idx;
  ttc_reg_pkg::ctrl_t    ctrl_q;
  ttc_reg_pkg::ctrl_t    ctrl_wdata;
  logic                  addr_hit;          // Offset is mapped
  logic                  wr_en;
  logic                  rd_en;

  // ----------------------------------------
  // Access decode
  // ----------------------------------------
  assign wr_en = psel & penable & pwrite & addr_hit;
  assign rd_en = psel & ~pwrite & addr_hit;    // Setup and access phase

  always_comb
  begin
    addr_hit = 1'b1;
    reg_idx  = ttc_reg_pkg::idx_ctrl;
    case (paddr)
      `TTC_OFF_CTRL:     reg_idx = ttc_reg_pkg::idx_ctrl;
      `TTC_OFF_INTERVAL: reg_idx = ttc_reg_pkg::idx_interval;
      `TTC_OFF_MATCH1:   reg_idx = ttc_reg_pkg::idx_match1;
      `TTC_OFF_MATCH2:   reg_idx = ttc_reg_pkg::idx_match2;
      `TTC_OFF_MATCH3:   reg_idx = ttc_reg_pkg::idx_match3;
      `TTC_OFF_COUNT:    reg_idx = ttc_reg_pkg::idx_count;
      `TTC_OFF_INTR:     reg_idx = ttc_reg_pkg::idx_intr;
      `TTC_OFF_INTR_EN:  reg_idx = ttc_reg_pkg::idx_intr_en;
      default:           addr_hit = 1'b0;      // Unmapped, no effect
    endcase
  end

  assign ctrl_wdata = ttc_reg_pkg::ctrl_t'(pwdata[5:0]);

  // Strobes to the interrupt block, access phase only
  assign intr_en_reg_sel = wr_en & (reg_idx == ttc_reg_pkg::idx_intr_en);
  assign clear_interrupt = rd_en & penable & (reg_idx == ttc_reg_pkg::idx_intr);

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------
  always_ff @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      ctrl_q       <= ttc_reg_pkg::CTRL_RESET;
      interval_val <= '0;
      match1_val   <= '0;
      match2_val   <= '0;
      match3_val   <= '0;
    end
    else
    begin
      ctrl_q.count_restart <= 1'b0;            // Self clearing
      if (wr_en)
      begin
        case (reg_idx)
          ttc_reg_pkg::idx_ctrl:     ctrl_q       <= ctrl_wdata;
          ttc_reg_pkg::idx_interval: interval_val <= pwdata[`TTC_CNT_W-1:0];
          ttc_reg_pkg::idx_match1:   match1_val   <= pwdata[`TTC_CNT_W-1:0];
          ttc_reg_pkg::idx_match2:   match2_val   <= pwdata[`TTC_CNT_W-1:0];
          ttc_reg_pkg::idx_match3:   match3_val   <= pwdata[`TTC_CNT_W-1:0];
          default:                   ;         // Read-only or interrupt side
        endcase
      end
    end
  end

  assign count_en      = ctrl_q.count_en;
  assign interval_mode = ctrl_q.interval_mode;
  assign match_en      = ctrl_q.match_en;
  assign count_restart = ctrl_q.count_restart;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (reg_idx)
        ttc_reg_pkg::idx_ctrl:     prdata[4:0] = ctrl_q[4:0];   // Restart reads 0
        ttc_reg_pkg::idx_interval: prdata[`TTC_CNT_W-1:0] = interval_val;
        ttc_reg_pkg::idx_match1:   prdata[`TTC_CNT_W-1:0] = match1_val;
        ttc_reg_pkg::idx_match2:   prdata[`TTC_CNT_W-1:0] = match2_val;
        ttc_reg_pkg::idx_match3:   prdata[`TTC_CNT_W-1:0] = match3_val;
        ttc_reg_pkg::idx_count:    prdata[`TTC_CNT_W-1:0] = count_val;
        ttc_reg_pkg::idx_intr:     prdata[5:0] = interrupt_reg_out.vec;
        ttc_reg_pkg::idx_intr_en:  prdata[5:0] = interrupt_en_out.vec;
        default:                   prdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/ttc_lite.sv ====
// Timer counter lite top: APB slave, counter and interrupt block wired together
`timescale 1ns/1ns
`include "ttc_defs.svh"

module ttc_lite (
  input  logic                   pclk22,
  input  logic                   n_p_reset22,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`TTC_ADDR_W-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   interrupt
);

  // ----------------------------------------
  // Regs to counter
  // ----------------------------------------
  logic                  count_en;
  logic                  interval_mode;
  logic [3:1]            match_en;
  logic                  count_restart;
  logic [`TTC_CNT_W-1:0] interval_val;
  logic [`TTC_CNT_W-1:0] match1_val;
  logic [`TTC_CNT_W-1:0] match2_val;
  logic [`TTC_CNT_W-1:0] match3_val;
  logic [`TTC_CNT_W-1:0] count_val;        // Back for readout

  // Counter events
  logic                  interval_intr;
  logic                  overflow_intr;
  logic [3:1]            match_intr;

  // Interrupt block side
  logic                     intr_en_reg_sel;
  logic                     clear_interrupt;
  ttc_intr_pkg::intr_word_u intr_status;   // Sticky status word
  ttc_intr_pkg::intr_word_u intr_enable;   // Enable mask word

  ttc_regs_lite u_regs (
    .pclk22            (pclk22),
    .n_p_reset22       (n_p_reset22),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .count_val         (count_val),
    .interrupt_reg_out (intr_status),
    .interrupt_en_out  (intr_enable),
    .prdata            (prdata),
    .count_en          (count_en),
    .interval_mode     (interval_mode),
    .match_en          (match_en),
    .count_restart     (count_restart),
    .interval_val      (interval_val),
    .match1_val        (match1_val),
    .match2_val        (match2_val),
    .match3_val        (match3_val),
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt)
  );

  ttc_counter_lite u_counter (
    .pclk22        (pclk22),
    .n_p_reset22   (n_p_reset22),
    .count_en      (count_en),
    .interval_mode (interval_mode),
    .match_en      (match_en),
    .count_restart (count_restart),
    .interval_val  (interval_val),
    .match1_val    (match1_val),
    .match2_val    (match2_val),
    .match3_val    (match3_val),
    .count_val     (count_val),
    .interval_intr (interval_intr),
    .overflow_intr (overflow_intr),
    .match_intr    (match_intr)
  );

  ttc_interrupt_lite u_interrupt (
    .pclk22            (pclk22),
    .n_p_reset22       (n_p_reset22),
    .pwdata            (pwdata[5:0]),      // Enable mask bits only
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt),
    .interval_intr     (interval_intr),
    .match_intr        (match_intr),
    .overflow_intr     (overflow_intr),
    .interrupt         (interrupt),
    .interrupt_reg_out (intr_status.vec),
    .interrupt_en_out  (intr_enable.vec)
  );

endmodule

// ==== test/ttc_lite_checker.sv ====
// Timer counter lite checker: compares read data and the interrupt line, counts errors
`timescale 1ns/1ns
`include "ttc_defs.svh"

module ttc_lite_checker (
  input  logic                   pclk22,
  input  logic                   n_p_reset22,
  input  logic                   psel,
  input  logic                   pwrite,
  input  logic [`TTC_ADDR_W-1:0] paddr,
  input  logic [31:0]            prdata,
  input  logic                   interrupt,
  input  logic                   cmp_valid,        // Compare on this edge
  input  logic                   cmp_kind,         // 0 prdata, 1 interrupt
  input  logic [31:0]            cmp_exp,
  output logic                   cmp_done,         // One-cycle ack
  output int                     mismatch_count,
  output int                     check_count
);

  // ----------------------------------------
  // Sampling on the rising edge
  // ----------------------------------------
  always @(posedge pclk22 or negedge n_p_reset22)
  begin
    if (!n_p_reset22)
    begin
      cmp_done       <= 1'b0;
      mismatch_count = 0;
      check_count    = 0;
    end
    else
    begin
      cmp_done <= cmp_valid;

      // No read in progress, so the bus must read zero
      if (!(psel && !pwrite) && prdata !== 32'h0)
      begin
        $display("MISMATCH prdata outside a read: expected 0x%08h, got 0x%08h",
                 32'h0, prdata);
        mismatch_count++;
      end

      if (cmp_valid && !cmp_kind)
      begin
        check_count++;
        if (prdata !== cmp_exp)
        begin
          $display("MISMATCH prdata at paddr 0x%02h: expected 0x%08h, got 0x%08h",
                   paddr, cmp_exp, prdata);
          mismatch_count++;
        end
      end

      if (cmp_valid && cmp_kind)
      begin
        check_count++;
        if (interrupt !== cmp_exp[0])
        begin
          $display("MISMATCH interrupt: expected 0x%0h, got 0x%0h", cmp_exp[0], interrupt);
          mismatch_count++;
        end
      end
    end
  end

endmodule

// ==== test/ttc_lite_tb.sv ====
// Timer counter lite testbench: clock, reset, case file reader and APB driver
`timescale 1ns/1ns
`include "ttc_defs.svh"

module ttc_lite_tb;

  localparam int CMP_TIMEOUT = 8;               // Cycles allowed for the checker ack

  logic                   pclk22;
  logic                   n_p_reset22;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`TTC_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   interrupt;

  // Compare request to the checker
  logic        cmp_valid;
  logic        cmp_kind;                        // 0 prdata, 1 interrupt line
  logic [31:0] cmp_exp;
  logic        cmp_done;
  int          mismatch_count;
  int          check_count;

  // Case file state
  int          fd;
  int          got;
  int          fields;
  int          step_no;
  int          other_errors;
  int unsigned rng_init;
  string       line;
  string       op;
  logic [31:0] f_addr;
  logic [31:0] f_data;
  logic [31:0] f_exp;

  ttc_lite uut (
    .pclk22      (pclk22),
    .n_p_reset22 (n_p_reset22),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .interrupt   (interrupt)
  );

  ttc_lite_checker u_checker (
    .pclk22         (pclk22),
    .n_p_reset22    (n_p_reset22),
    .psel           (psel),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .prdata         (prdata),
    .interrupt      (interrupt),
    .cmp_valid      (cmp_valid),
    .cmp_kind       (cmp_kind),
    .cmp_exp        (cmp_exp),
    .cmp_done       (cmp_done),
    .mismatch_count (mismatch_count),
    .check_count    (check_count)
  );

  // 20 ns clock
  initial
  begin
    pclk22 = 1'b0;
    forever #10 pclk22 = ~pclk22;
  end

  // ----------------------------------------
  // Bus and compare helpers
  // ----------------------------------------
  task automatic run_idle(input int unsigned cycles);
    repeat (cycles) @(negedge pclk22);
  endtask

  // Ack is registered, so it is already up on the falling edge after the sample
  task automatic await_compare();
    int waited;
    waited = 0;
    while (!cmp_done && waited < CMP_TIMEOUT)
    begin
      @(negedge pclk22);
      waited++;
    end
    if (!cmp_done)
    begin
      $display("Timeout: checker gave no ack for step %0d within %0d cycles",
               step_no, CMP_TIMEOUT);
      other_errors++;
    end
  endtask

  task automatic bus_write(input logic [`TTC_ADDR_W-1:0] a, input logic [31:0] d);
    @(negedge pclk22);
    psel    = 1'b1;                             // Setup phase
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    penable = 1'b0;
    @(negedge pclk22);
    penable = 1'b1;                             // Access, write lands next edge
    @(negedge pclk22);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_and_compare(input logic [`TTC_ADDR_W-1:0] a, input logic [31:0] e);
    @(negedge pclk22);
    psel      = 1'b1;
    pwrite    = 1'b0;
    paddr     = a;
    penable   = 1'b0;
    @(negedge pclk22);
    penable   = 1'b1;
    cmp_valid = 1'b1;                           // Sampled in the access cycle
    cmp_kind  = 1'b0;
    cmp_exp   = e;
    @(negedge pclk22);
    psel      = 1'b0;
    penable   = 1'b0;
    cmp_valid = 1'b0;
    await_compare();
  endtask

  task automatic check_level(input logic e);
    @(negedge pclk22);
    cmp_valid = 1'b1;
    cmp_kind  = 1'b1;
    cmp_exp   = {31'b0, e};
    @(negedge pclk22);
    cmp_valid = 1'b0;
    await_compare();
  endtask

  // One line of the case file, comments and blank lines skipped
  task automatic apply_line();
    fields = $sscanf(line, "%s %h %h %h", op, f_addr, f_data, f_exp);
    if (fields >= 1 && op.getc(0) != "#")
    begin
      step_no++;
      if (fields != 4)
      begin
        $display("Case line %0d is malformed: %s", step_no, line);
        other_errors++;
      end
      else if (op == "W")
        bus_write(f_addr[`TTC_ADDR_W-1:0], f_data);
      else if (op == "R")
        read_and_compare(f_addr[`TTC_ADDR_W-1:0], f_exp);
      else if (op == "I")
        run_idle(f_data);
      else if (op == "L")
        check_level(f_exp[0]);
      else
      begin
        $display("Case line %0d has an unknown operation %s", step_no, op);
        other_errors++;
      end
      run_idle($urandom % 3);                   // Random gap, 0 to 2 cycles
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    n_p_reset22  = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    cmp_valid    = 1'b0;
    cmp_kind     = 1'b0;
    cmp_exp      = '0;
    step_no      = 0;
    other_errors = 0;
    rng_init     = $urandom(32'hffaf_8fcd);     // Only seeding call
    repeat (5) @(negedge pclk22);
    n_p_reset22  = 1'b1;

    fd = $fopen("test/ttc_lite_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file test/ttc_lite_cases.txt");
      other_errors++;
    end
    else
    begin
      got = $fgets(line, fd);
      while (got != 0)
      begin
        apply_line();
        got = $fgets(line, fd);
      end
      $fclose(fd);
    end

    run_idle(4);                                // Let the last compare settle
    $display("Checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0 && check_count > 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== test/ttc_lite_cases.txt ====
# Columns: op addr data expect, all hex. W write, R read and compare with expect,
# I idle for data cycles, L compare the interrupt line with expect bit 0
# Register readback and restart
W 04 0000000a 00000000
R 04 00000000 0000000a
W 08 00001234 00000000
R 08 00000000 00001234
W 0c 0000beef 00000000
R 0c 00000000 0000beef
W 10 0000ffff 00000000
R 10 00000000 0000ffff
W 1c ffffffff 00000000
R 1c 00000000 0000003f
W 1c 00000000 00000000
W 00 00000001 00000000
I 00 00000008 00000000
W 00 00000020 00000000
R 14 00000000 00000000
R 00 00000000 00000000
R 18 00000000 00000000
# Interval mode, interval 10, interval source enabled
W 1c 00000001 00000000
W 00 00000023 00000000
I 00 00000010 00000000
L 00 00000000 00000001
W 00 00000002 00000000
I 00 00000004 00000000
R 18 00000000 00000001
R 18 00000000 00000000
L 00 00000000 00000000
# Counter held on match 2 value, only match 2 enabled
W 0c 00000000 00000000
W 1c 00000004 00000000
W 00 00000028 00000000
I 00 00000006 00000000
R 14 00000000 00000000
R 00 00000000 00000008
L 00 00000000 00000001
R 18 00000000 00000004
I 00 00000008 00000000
R 18 00000000 00000000
L 00 00000000 00000000
# All sources disabled while the counter runs
W 1c 00000000 00000000
W 04 00000003 00000000
W 00 0000001f 00000000
I 00 00000020 00000000
R 18 00000000 00000000
L 00 00000000 00000000
# Overflow mode, overflow source enabled
W 00 00000020 00000000
W 1c 00000010 00000000
R 18 00000000 00000000
W 00 00000021 00000000
I 00 00010004 00000000
L 00 00000000 00000001
R 18 00000000 00000010
R 18 00000000 00000000
L 00 00000000 00000000

// ==== filelist.f ====
+incdir+rtl
rtl/ttc_reg_pkg.sv
rtl/ttc_intr_pkg.sv
rtl/ttc_counter_lite.sv
rtl/ttc_interrupt_lite.sv
rtl/ttc_regs_lite.sv
rtl/ttc_lite.sv
test/ttc_lite_checker.sv
test/ttc_lite_tb.sv

// ==== Bender.yml ====
package:
  name: ttc_lite

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ttc_reg_pkg.sv
      - rtl/ttc_intr_pkg.sv
      - rtl/ttc_counter_lite.sv
      - rtl/ttc_interrupt_lite.sv
      - rtl/ttc_regs_lite.sv
      - rtl/ttc_lite.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/ttc_lite_checker.sv
      - test/ttc_lite_tb.sv
